// ==== pucrs_rv.f ====
+incdir+testbench
design/rv_pkg.sv
design/fetch.sv
design/decoder.sv
design/regbank.sv
design/execute.sv
design/retire.sv
design/pucrs_rv.sv
testbench/tb_pucrs_rv.sv

// ==== testbench/rv_iss_model.svh ====
// LFSR random source, fill pattern, random program generator and instruction-set reference model
`ifndef RV_ISS_MODEL_SVH
`define RV_ISS_MODEL_SVH

// Fibonacci LFSR state, taps at bits 32, 22, 2 and 1
logic [31:0] lfsr = 32'd42;
// word index of the closing self jump, the model stops when it gets there
int          halt_idx;
logic [31:0] model_mem [0:1023];
// expected store stream as {address, data} in program order
logic [63:0] exp_q [$];

// one LFSR step for every bit handed out
function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] val;
    logic        fb;
    val = '0;
    for (int i = 0; i < n; i++) begin
        fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
        lfsr = {lfsr[30:0], fb};
        val  = {val[30:0], fb};
    end
    return val;
endfunction

// data area contents before a program runs, every address bit takes part
function automatic logic [31:0] fill_word(input logic [31:0] addr);
    return (addr * 32'h9e37_79b9) ^ {addr[15:0], addr[31:16]};
endfunction

// RV32I integer operations selected by funct3, sub picks SUB over ADD
function automatic logic [31:0] alu_ref(input logic [2:0] f3, input logic sub,
                                        input logic [31:0] a, input logic [31:0] b);
    case (f3)
        3'b000:  return sub ? a - b : a + b;
        3'b001:  return a << b[4:0];
        3'b010:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
        3'b100:  return a ^ b;
        3'b101:  return a >> b[4:0];
        3'b110:  return a | b;
        default: return a & b;
    endcase
endfunction

task automatic gen_program();
    int          n;
    logic [2:0]  kind;
    logic [4:0]  rd;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [2:0]  f3;
    logic [11:0] imm;
    logic        prev_sw;
    n       = 0;
    prev_sw = 1'b0;
    // the program area stays zero so a fetch past the end decodes as a no-op
    for (int a = 0; a < 1024; a++) begin
        mem[a] = (a < 256) ? 32'd0 : fill_word(a * 4);
    end
    // every register gets a random value through a dependent LUI and ADDI pair
    for (int r = 1; r < 32; r++) begin
        mem[n]     = {20'(rand_bits(20)), 5'(r), 7'b0110111};
        mem[n + 1] = {12'(rand_bits(12)), 5'(r), 3'b000, 5'(r), 7'b0010011};
        n          = n + 2;
    end
    for (int k = 0; k < 80; k++) begin
        kind = 3'(rand_bits(3));
        rd   = 5'(rand_bits(5));
        rs1  = 5'(rand_bits(5));
        rs2  = (rand_bits(1) != 0) ? rs1 : 5'(rand_bits(5));
        f3   = 3'(rand_bits(3));
        // SLTU is not in the subset
        if (f3 == 3'b011) begin
            f3 = 3'b000;
        end
        // memory sees a store one cycle too late for a load right behind it
        if (kind == 3'd3 && prev_sw) begin
            kind = 3'd0;
        end
        prev_sw = (kind == 3'd4);
        case (kind)
            3'd0, 3'd1: begin
                mem[n] = {1'b0, (f3 == 3'b000) && (rand_bits(1) != 0), 5'd0, rs2, rs1, f3,
                          rd, 7'b0110011};
            end
            3'd2: begin
                // shift immediates keep the upper seven bits at zero
                imm    = (f3 == 3'b001 || f3 == 3'b101) ? 12'(rand_bits(5)) : 12'(rand_bits(12));
                mem[n] = {imm, rs1, f3, rd, 7'b0010011};
            end
            3'd3: begin
                // loads and stores use x0 as base so even wrong-path addresses stay aligned
                imm    = 12'h400 + 12'(4 * rand_bits(4));
                mem[n] = {imm, 5'd0, 3'b010, rd, 7'b0000011};
            end
            3'd4: begin
                imm    = 12'h400 + 12'(4 * rand_bits(4));
                mem[n] = {imm[11:5], rs2, 5'd0, 3'b010, imm[4:0], 7'b0100011};
            end
            3'd5: begin
                // forward BEQ or BNE skipping up to three instructions
                imm    = 12'(4 + 4 * rand_bits(2));
                mem[n] = {7'd0, rs2, rs1, 2'b00, 1'(rand_bits(1)), imm[4:1], 1'b0, 7'b1100011};
            end
            3'd6: begin
                imm    = 12'(4 + 4 * rand_bits(2));
                mem[n] = {1'b0, imm[10:1], 1'b0, 8'd0, rd, 7'b1101111};
            end
            default: mem[n] = {20'(rand_bits(20)), rd, 7'b0110111};
        endcase
        n = n + 1;
    end
    // dump x1 to x31 into the result area at 0x600
    for (int r = 1; r < 32; r++) begin
        imm    = 12'h600 + 12'(4 * r);
        mem[n] = {imm[11:5], 5'(r), 5'd0, 3'b010, imm[4:0], 7'b0100011};
        n      = n + 1;
    end
    // JAL x0 to itself parks the core
    mem[n]   = 32'h0000_006f;
    halt_idx = n;
endtask

// runs the program from address zero, where the core starts, and records every store
task automatic run_model();
    logic [31:0] x [0:31];
    logic [31:0] pc;
    logic [31:0] w;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] addr;
    logic [31:0] npc;
    exp_q.delete();
    pc = 32'd0;
    for (int i = 0; i < 32; i++) begin
        x[i] = 32'd0;
    end
    for (int i = 0; i < 1024; i++) begin
        model_mem[i] = mem[i];
    end
    for (int s = 0; s < 4096 && pc != 32'(4 * halt_idx); s++) begin
        w   = model_mem[pc[11:2]];
        a   = x[w[19:15]];
        b   = x[w[24:20]];
        npc = pc + 32'd4;
        case (w[6:0])
            7'b0110011: x[w[11:7]] = alu_ref(w[14:12], w[30], a, b);
            7'b0010011: x[w[11:7]] = alu_ref(w[14:12], 1'b0, a, {{20{w[31]}}, w[31:20]});
            7'b0110111: x[w[11:7]] = {w[31:12], 12'h000};
            7'b0000011: begin
                addr       = a + {{20{w[31]}}, w[31:20]};
                x[w[11:7]] = model_mem[addr[11:2]];
            end
            7'b0100011: begin
                addr                  = a + {{20{w[31]}}, w[31:25], w[11:7]};
                model_mem[addr[11:2]] = b;
                exp_q.push_back({addr, b});
            end
            7'b1100011: begin
                // funct3 bit 0 clear is BEQ, set is BNE
                if ((w[12] == 1'b0) == (a == b)) begin
                    npc = pc + {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
                end
            end
            7'b1101111: begin
                x[w[11:7]] = pc + 32'd4;
                npc        = pc + {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
            end
            default: ;
        endcase
        x[0] = 32'd0;
        pc   = npc;
    end
endtask

`endif

// ==== testbench/tb_pucrs_rv.sv ====
// testbench for the core with clock, reset, shared memory, store stream checks and run control
`timescale 1ns/10ps
`default_nettype none

module tb_pucrs_rv;

    localparam logic [31:0] RESET_PC  = 32'h0000_0000;
    localparam int          NUM_PROGS = 8;
    localparam int          MAX_WAIT  = 4000;

    logic        clk;
    logic        i_rst;
    logic [31:0] i_instruction;
    logic [31:0] i_data_in;
    logic [31:0] o_i_address;
    logic        o_read;
    logic [31:0] o_read_address;
    logic [31:0] o_data_out;
    logic [31:0] o_write_address;
    logic [3:0]  o_write;

    // one 4 KB word memory holds program, data area and result area
    logic [31:0] mem [0:1023];
    logic [31:0] load_word;
    int          n_seen;

    `include "rv_iss_model.svh"

    pucrs_rv #(
        .RESET_PC(RESET_PC)
    ) i_pucrs_rv (
        .clk(clk), .i_rst(i_rst), .i_instruction(i_instruction), .o_i_address(o_i_address),
        .o_read(o_read), .o_read_address(o_read_address), .i_data_in(i_data_in),
        .o_data_out(o_data_out), .o_write_address(o_write_address), .o_write(o_write)
    );

    // instruction side answers in the same cycle
    assign i_instruction = mem[o_i_address[11:2]];

    initial begin
        clk = 1'b0;
        forever begin
            #50 clk = ~clk;
        end
    end

    task automatic stop_run();
        $display(">>> FAIL");
        $fatal(1, "simulation stopped on the first error");
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            $display("Error at %0t: %s expected %h, got %h", $time, name, expected, actual);
            stop_run();
        end
    endtask

    // outputs are looked at mid-cycle, well away from the rising edge
    always @(negedge clk) begin
        if (!i_rst && o_write !== 4'b0000) begin
            check_value("o_write", 32'hf, o_write);
            if (n_seen >= exp_q.size()) begin
                $display("unexpected store to %h at %0t after the whole stream",
                         o_write_address, $time);
                stop_run();
            end
            check_value("o_write_address", exp_q[n_seen][63:32], o_write_address);
            check_value("o_data_out", exp_q[n_seen][31:0], o_data_out);
            mem[o_write_address[11:2]] = o_data_out;
            n_seen = n_seen + 1;
        end
        // a store seen in this cycle is already in memory for a read strobed now
        if (o_read === 1'b1) begin
            load_word = mem[o_read_address[11:2]];
        end
    end

    // load data follows the strobe by one cycle
    always @(posedge clk) begin
        i_data_in <= load_word;
    end

    // holds reset for 8 cycles and loads the next program while the core is held
    task automatic reset_core();
        @(posedge clk);
        i_rst <= 1'b1;
        for (int c = 0; c < 8; c++) begin
            @(posedge clk);
            if (c == 7) begin
                i_rst <= 1'b0;
            end
            @(negedge clk);
            if (c == 0) begin
                gen_program();
                run_model();
                n_seen = 0;
            end
            // the last pass lands in the first cycle after reset
            check_value("o_i_address", RESET_PC, o_i_address);
            check_value("o_read", 32'd0, o_read);
            check_value("o_write", 32'd0, o_write);
        end
    endtask

    task automatic wait_stores(input int prog);
        int cycles;
        cycles = 0;
        while (n_seen < exp_q.size()) begin
            @(posedge clk);
            cycles = cycles + 1;
            if (cycles > MAX_WAIT) begin
                $display("program %0d timed out with %0d of %0d stores seen",
                         prog, n_seen, exp_q.size());
                stop_run();
            end
        end
    endtask

    initial begin
        i_rst     = 1'b1;
        i_data_in = 32'd0;
        load_word = 32'd0;
        n_seen    = 0;
        for (int a = 0; a < 1024; a++) begin
            mem[a] = 32'd0;
        end
        for (int p = 0; p < NUM_PROGS; p++) begin
            reset_core();
            wait_stores(p);
            // the core now spins on its self jump, any further store is caught by the monitor
            repeat (20) @(posedge clk);
        end
        $display(">>> PASS");
        $finish;
    end

endmodule

`default_nettype wire

// ==== design/pucrs_rv.sv ====
// core top level connecting fetch, decoder, execute, retire and the register bank
`timescale 1ns/10ps
`default_nettype none

module pucrs_rv #(
    parameter logic [31:0] RESET_PC = 32'h0000_0000
) (
    input  logic        clk,
    input  logic        i_rst,
    input  logic [31:0] i_instruction,
    output logic [31:0] o_i_address,
    output logic        o_read,
    output logic [31:0] o_read_address,
    input  logic [31:0] i_data_in,
    output logic [31:0] o_data_out,
    output logic [31:0] o_write_address,
    output logic [3:0]  o_write
);

    // stage boundary registers
    rv_pkg::fetch_s fetch_q;
    rv_pkg::exec_s  exec_q;
    rv_pkg::ret_s   ret_q;

    // feedback from retire and the decoder
    logic                     stall;
    logic                     jump;
    logic [31:0]              new_pc;
    logic [rv_pkg::TAG_W-1:0] cur_tag;

    // register bank traffic
    logic [4:0]  reg_a;
    logic [4:0]  reg_b;
    logic [31:0] data_a;
    logic [31:0] data_b;
    logic        reg_we;
    logic [4:0]  reg_addr;
    logic [31:0] wr_data;

    fetch #(
        .RESET_PC(RESET_PC)
    ) fetch1 (
        .clk(clk), .i_rst(i_rst), .i_stall(stall), .i_jump(jump), .i_new_pc(new_pc),
        .i_cur_tag(cur_tag), .o_i_address(o_i_address), .o_fetch(fetch_q)
    );

    // the decoder sees both downstream structs to find pending writes
    decoder decoder1 (
        .clk(clk), .i_rst(i_rst), .i_fetch(fetch_q), .i_instruction(i_instruction),
        .i_data_a(data_a), .i_data_b(data_b), .i_ex_busy(exec_q), .i_ret_busy(ret_q),
        .o_reg_a(reg_a), .o_reg_b(reg_b), .o_stall(stall), .o_exec(exec_q)
    );

    execute execute1 (
        .clk(clk), .i_rst(i_rst), .i_exec(exec_q), .o_ret(ret_q),
        .o_read(o_read), .o_read_address(o_read_address)
    );

    retire retire1 (
        .clk(clk), .i_rst(i_rst), .i_ret(ret_q), .i_data_in(i_data_in),
        .o_reg_we(reg_we), .o_reg_addr(reg_addr), .o_wr_data(wr_data),
        .o_jump(jump), .o_new_pc(new_pc), .o_cur_tag(cur_tag),
        .o_write(o_write), .o_write_address(o_write_address), .o_data_out(o_data_out)
    );

    regbank regbank1 (
        .clk(clk), .i_rst(i_rst), .i_addr_a(reg_a), .i_addr_b(reg_b),
        .i_we(reg_we), .i_addr_w(reg_addr), .i_wr_data(wr_data),
        .o_data_a(data_a), .o_data_b(data_b)
    );

endmodule

`default_nettype wire

// ==== design/retire.sv ====
// tag filter, register write-back, load capture, store strobe and jump redirect
`timescale 1ns/10ps
`default_nettype none

module retire (
    input  logic                      clk,
    input  logic                      i_rst,
    input  rv_pkg::ret_s              i_ret,
    input  logic [31:0]               i_data_in,
    output logic                      o_reg_we,
    output logic [4:0]                o_reg_addr,
    output logic [31:0]               o_wr_data,
    output logic                      o_jump,
    output logic [31:0]               o_new_pc,
    output logic [rv_pkg::TAG_W-1:0]  o_cur_tag,
    output logic [3:0]                o_write,
    output logic [31:0]               o_write_address,
    output logic [31:0]               o_data_out
);

    logic [rv_pkg::TAG_W-1:0] cur_tag;
    logic                     act;

    // wrong-path instructions still carry the tag from before the last redirect
    assign act       = i_ret.valid && (i_ret.tag == cur_tag);
    assign o_cur_tag = cur_tag;

    always_ff @(posedge clk) begin
        o_reg_addr      <= i_ret.rd;
        o_write_address <= i_ret.result;
        o_data_out      <= i_ret.store_data;
        o_new_pc        <= i_ret.target;
        // load data shows up from memory during this cycle
        o_wr_data       <= (i_ret.op == rv_pkg::OP_LW) ? i_data_in : i_ret.result;

        // rd is already zero for stores, branches and no-ops
        o_reg_we <= act && (i_ret.rd != 5'd0);
        o_write  <= (act && i_ret.op == rv_pkg::OP_SW) ? 4'b1111 : 4'b0000;
        o_jump   <= act && i_ret.jump;
        if (act && i_ret.jump) begin
            cur_tag <= cur_tag + 1'b1;
        end

        if (i_rst) begin
            cur_tag  <= '0;
            o_reg_we <= 1'b0;
            o_write  <= 4'b0000;
            o_jump   <= 1'b0;
        end
    end

endmodule

`default_nettype wire

// ==== design/execute.sv ====
// ALU, branch compare, jump target and memory address, load strobe and execute-to-retire register
`timescale 1ns/10ps
`default_nettype none

module execute (
    input  logic           clk,
    input  logic           i_rst,
    input  rv_pkg::exec_s  i_exec,
    output rv_pkg::ret_s   o_ret,
    output logic           o_read,
    output logic [31:0]    o_read_address
);

    logic [31:0] alu_out;
    logic [31:0] addr;
    logic [31:0] target;
    logic        taken;
    logic        is_mem;

    always_comb begin
        case (i_exec.alu)
            rv_pkg::ADD: alu_out = i_exec.opa + i_exec.opb;
            rv_pkg::SUB: alu_out = i_exec.opa - i_exec.opb;
            rv_pkg::AND: alu_out = i_exec.opa & i_exec.opb;
            rv_pkg::OR:  alu_out = i_exec.opa | i_exec.opb;
            rv_pkg::XOR: alu_out = i_exec.opa ^ i_exec.opb;
            rv_pkg::SLT: alu_out = {31'd0, $signed(i_exec.opa) < $signed(i_exec.opb)};
            rv_pkg::SLL: alu_out = i_exec.opa << i_exec.opb[4:0];
            rv_pkg::SRL: alu_out = i_exec.opa >> i_exec.opb[4:0];
            default:     alu_out = i_exec.opa + i_exec.opb;
        endcase
    end

    // branches compare the two register operands, JAL is always taken
    always_comb begin
        case (i_exec.op)
            rv_pkg::OP_BEQ: taken = (i_exec.opa == i_exec.opb);
            rv_pkg::OP_BNE: taken = (i_exec.opa != i_exec.opb);
            rv_pkg::OP_JAL: taken = 1'b1;
            default:        taken = 1'b0;
        endcase
    end

    assign addr   = i_exec.opa + i_exec.imm;
    assign target = i_exec.pc + i_exec.imm;
    assign is_mem = (i_exec.op == rv_pkg::OP_LW) || (i_exec.op == rv_pkg::OP_SW);

    // the read goes out now so the word is on i_data_in while the load sits in retire
    assign o_read         = i_exec.valid && (i_exec.op == rv_pkg::OP_LW);
    assign o_read_address = addr;

    always_ff @(posedge clk) begin
        o_ret.valid      <= i_exec.valid;
        o_ret.tag        <= i_exec.tag;
        o_ret.op         <= i_exec.op;
        o_ret.rd         <= i_exec.rd;
        o_ret.store_data <= i_exec.opc;
        o_ret.jump       <= taken;
        o_ret.target     <= target;
        // JAL arrives with opa = pc+4 and opb = 0, so the ALU already gives the link value
        o_ret.result     <= is_mem ? addr : alu_out;

        if (i_rst) begin
            o_ret.valid <= 1'b0;
        end
    end

    // only word accesses exist, a misaligned address means a bad base or offset
    a_read_aligned: assert property (
        @(posedge clk) disable iff (i_rst) o_read |-> o_read_address[1:0] == 2'b00
    );

endmodule

`default_nettype wire

// ==== design/regbank.sv ====
// 31-entry register bank with two read ports and write-through bypass
`timescale 1ns/10ps
`default_nettype none

module regbank (
    input  logic        clk,
    input  logic        i_rst,
    input  logic [4:0]  i_addr_a,
    input  logic [4:0]  i_addr_b,
    input  logic        i_we,
    input  logic [4:0]  i_addr_w,
    input  logic [31:0] i_wr_data,
    output logic [31:0] o_data_a,
    output logic [31:0] o_data_b
);

    logic [31:0] regs [1:31];

    // x0 is hardwired, a register written this cycle returns its new value
    function automatic logic [31:0] read_port(input logic [4:0] addr);
        if (addr == 5'd0) begin
            return 32'd0;
        end
        if (i_we && addr == i_addr_w) begin
            return i_wr_data;
        end
        return regs[addr];
    endfunction

    always_comb begin
        o_data_a = read_port(i_addr_a);
        o_data_b = read_port(i_addr_b);
    end

    always_ff @(posedge clk) begin
        if (i_rst) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= 32'd0;
            end
        end else if (i_we && i_addr_w != 5'd0) begin
            regs[i_addr_w] <= i_wr_data;
        end
    end

    // decode zeroes rd for x0 destinations, so retire never asks for this write
    a_no_x0_write: assert property (
        @(posedge clk) disable iff (i_rst) i_we |-> i_addr_w != 5'd0
    );

endmodule

`default_nettype wire

// ==== design/decoder.sv ====
// RV32I subset decoder with immediates, operand selection, RAW stall and decode-to-execute register
`timescale 1ns/10ps
`default_nettype none

module decoder (
    input  logic            clk,
    input  logic            i_rst,
    input  rv_pkg::fetch_s  i_fetch,
    input  logic [31:0]     i_instruction,
    input  logic [31:0]     i_data_a,
    input  logic [31:0]     i_data_b,
    input  rv_pkg::exec_s   i_ex_busy,
    input  rv_pkg::ret_s    i_ret_busy,
    output logic [4:0]      o_reg_a,
    output logic [4:0]      o_reg_b,
    output logic            o_stall,
    output rv_pkg::exec_s   o_exec
);

    logic [31:0]  instr_q;
    logic [6:0]   opcode;
    logic [2:0]   funct3;
    logic [4:0]   rs1;
    logic [4:0]   rs2;
    logic [31:0]  imm_i;
    logic [31:0]  imm_s;
    logic [31:0]  imm_b;
    logic [31:0]  imm_j;
    logic [31:0]  imm_u;
    logic [31:0]  imm;
    rv_pkg::op_e  op;
    rv_pkg::alu_e alu;
    rv_pkg::alu_e alu_f3;
    logic         use_a;
    logic         use_b;
    logic         haz_a;
    logic         haz_b;
    logic [4:0]   rd;

    // the fetched word is held here in step with the fetch register
    assign opcode = instr_q[6:0];
    assign funct3 = instr_q[14:12];
    assign rs1    = instr_q[19:15];
    assign rs2    = instr_q[24:20];

    assign o_reg_a = rs1;
    assign o_reg_b = rs2;

    assign imm_i = {{20{instr_q[31]}}, instr_q[31:20]};
    assign imm_s = {{20{instr_q[31]}}, instr_q[31:25], instr_q[11:7]};
    assign imm_b = {{19{instr_q[31]}}, instr_q[31], instr_q[7], instr_q[30:25],
                    instr_q[11:8], 1'b0};
    assign imm_j = {{11{instr_q[31]}}, instr_q[31], instr_q[19:12], instr_q[20],
                    instr_q[30:21], 1'b0};
    assign imm_u = {instr_q[31:12], 12'h000};

    // funct3 mapping shared by the register and immediate ALU forms
    always_comb begin
        case (funct3)
            3'b001:  alu_f3 = rv_pkg::SLL;
            3'b010:  alu_f3 = rv_pkg::SLT;
            3'b100:  alu_f3 = rv_pkg::XOR;
            3'b101:  alu_f3 = rv_pkg::SRL;
            3'b110:  alu_f3 = rv_pkg::OR;
            3'b111:  alu_f3 = rv_pkg::AND;
            default: alu_f3 = rv_pkg::ADD;
        endcase
    end

    always_comb begin
        op    = rv_pkg::OP_NOP;
        alu   = rv_pkg::ADD;
        imm   = imm_i;
        use_a = 1'b0;
        use_b = 1'b0;
        case (opcode)
            7'b0110011: begin
                // SLTU, SRA and any other funct7 variant fall back to a no-op
                use_a = 1'b1;
                use_b = 1'b1;
                alu   = (funct3 == 3'b000 && instr_q[30]) ? rv_pkg::SUB : alu_f3;
                if (funct3 != 3'b011 && !(instr_q[30] && funct3 != 3'b000)) begin
                    op = rv_pkg::OP_ALU;
                end
            end
            7'b0010011: begin
                use_a = 1'b1;
                alu   = alu_f3;
                if (funct3 != 3'b011 && !(funct3 == 3'b101 && instr_q[30])) begin
                    op = rv_pkg::OP_ALUI;
                end
            end
            7'b0110111: begin
                op  = rv_pkg::OP_LUI;
                imm = imm_u;
            end
            7'b0000011: begin
                use_a = 1'b1;
                op    = (funct3 == 3'b010) ? rv_pkg::OP_LW : rv_pkg::OP_NOP;
            end
            7'b0100011: begin
                use_a = 1'b1;
                use_b = 1'b1;
                imm   = imm_s;
                op    = (funct3 == 3'b010) ? rv_pkg::OP_SW : rv_pkg::OP_NOP;
            end
            7'b1100011: begin
                use_a = 1'b1;
                use_b = 1'b1;
                imm   = imm_b;
                if (funct3 == 3'b000) begin
                    op = rv_pkg::OP_BEQ;
                end else if (funct3 == 3'b001) begin
                    op = rv_pkg::OP_BNE;
                end
            end
            7'b1101111: begin
                op  = rv_pkg::OP_JAL;
                imm = imm_j;
            end
            default: op = rv_pkg::OP_NOP;
        endcase
    end

    // only writing instructions keep their rd, so a nonzero rd downstream means a pending write
    always_comb begin
        case (op)
            rv_pkg::OP_ALU, rv_pkg::OP_ALUI, rv_pkg::OP_LUI, rv_pkg::OP_LW,
            rv_pkg::OP_JAL: rd = instr_q[11:7];
            default:        rd = 5'd0;
        endcase
    end

    // read-after-write against execute and retire
    // once the producer leaves retire the write-through bank covers it
    assign haz_a = use_a && (rs1 != 5'd0) &&
                   ((i_ex_busy.valid && i_ex_busy.rd == rs1) ||
                    (i_ret_busy.valid && i_ret_busy.rd == rs1));
    assign haz_b = use_b && (rs2 != 5'd0) &&
                   ((i_ex_busy.valid && i_ex_busy.rd == rs2) ||
                    (i_ret_busy.valid && i_ret_busy.rd == rs2));
    assign o_stall = i_fetch.valid && (haz_a || haz_b);

    always_ff @(posedge clk) begin
        if (!o_stall) begin
            instr_q <= i_instruction;
        end

        // a stall sends a bubble down while fetch and instr_q hold
        o_exec.valid <= i_fetch.valid && !o_stall;
        o_exec.tag   <= i_fetch.tag;
        o_exec.op    <= op;
        o_exec.alu   <= alu;
        o_exec.pc    <= i_fetch.pc;
        o_exec.imm   <= imm;
        o_exec.rd    <= rd;
        o_exec.opc   <= i_data_b;

        // LUI adds its immediate to zero and JAL passes npc through as the link value
        if (op == rv_pkg::OP_LUI) begin
            o_exec.opa <= 32'd0;
        end else if (op == rv_pkg::OP_JAL) begin
            o_exec.opa <= i_fetch.npc;
        end else begin
            o_exec.opa <= i_data_a;
        end
        if (op == rv_pkg::OP_ALUI || op == rv_pkg::OP_LUI) begin
            o_exec.opb <= imm;
        end else if (op == rv_pkg::OP_JAL) begin
            o_exec.opb <= 32'd0;
        end else begin
            o_exec.opb <= i_data_b;
        end

        if (i_rst) begin
            o_exec.valid <= 1'b0;
        end
    end

    // the bubbles a stall sends down let the producers drain within two cycles
    a_stall_bounded: assert property (
        @(posedge clk) disable iff (i_rst) o_stall ##1 o_stall |=> !o_stall
    );

endmodule

`default_nettype wire

// ==== design/fetch.sv ====
// program counter with jump redirect and stall hold, and the fetch-to-decode register
`timescale 1ns/10ps
`default_nettype none

module fetch #(
    parameter logic [31:0] RESET_PC = 32'h0000_0000
) (
    input  logic                         clk,
    input  logic                         i_rst,
    input  logic                         i_stall,
    input  logic                         i_jump,
    input  logic [31:0]                  i_new_pc,
    input  logic [rv_pkg::TAG_W-1:0]     i_cur_tag,
    output logic [31:0]                  o_i_address,
    output rv_pkg::fetch_s               o_fetch
);

    logic [31:0] pc;
    logic [31:0] pc_plus4;

    // memory answers combinationally, so the word for pc arrives in this same cycle
    assign o_i_address = pc;
    assign pc_plus4    = pc + 32'd4;

    always_ff @(posedge clk) begin
        // a redirect from retire wins over a decoder stall
        if (i_jump) begin
            pc <= i_new_pc;
        end else if (!i_stall) begin
            pc <= pc_plus4;
        end

        // the word fetched while the redirect is visible is on the wrong path
        // retire has already moved to the new tag, so it is killed here instead
        if (i_jump || !i_stall) begin
            o_fetch.valid <= !i_jump;
            o_fetch.pc    <= pc;
            o_fetch.npc   <= pc_plus4;
            o_fetch.tag   <= i_cur_tag;
        end

        if (i_rst) begin
            pc            <= RESET_PC;
            o_fetch.valid <= 1'b0;
        end
    end

endmodule

`default_nettype wire

// ==== design/rv_pkg.sv ====
// instruction kind and ALU enums, the tag width and the three pipeline stage structs
`default_nettype none

package rv_pkg;

    // every instruction carries a tag, a taken jump moves retire to the next tag
    localparam int TAG_W = 4;

    // supported instruction kinds
    // anything the decoder does not recognise becomes OP_NOP and flows through harmlessly
    typedef enum logic [3:0] {
        OP_NOP,
        OP_ALU,
        OP_ALUI,
        OP_LUI,
        OP_LW,
        OP_SW,
        OP_BEQ,
        OP_BNE,
        OP_JAL
    } op_e;

    // ALU functions, LUI and JAL reuse ADD with a zero operand
    typedef enum logic [2:0] {
        ADD,
        SUB,
        AND,
        OR,
        XOR,
        SLT,
        SLL,
        SRL
    } alu_e;

    // fetch to decode, the instruction word itself comes straight from memory
    typedef struct packed {
        logic             valid;
        logic [31:0]      pc;
        logic [31:0]      npc;
        logic [TAG_W-1:0] tag;
    } fetch_s;

    // decode to execute, opc is the store data and rd is zero for non-writing ops
    typedef struct packed {
        logic             valid;
        logic [TAG_W-1:0] tag;
        op_e              op;
        alu_e             alu;
        logic [31:0]      opa;
        logic [31:0]      opb;
        logic [31:0]      opc;
        logic [31:0]      pc;
        logic [31:0]      imm;
        logic [4:0]       rd;
    } exec_s;

    // execute to retire
    // result is the ALU value, the link address or the memory address
    typedef struct packed {
        logic             valid;
        logic [TAG_W-1:0] tag;
        op_e              op;
        logic [31:0]      result;
        logic [31:0]      store_data;
        logic             jump;
        logic [31:0]      target;
        logic [4:0]       rd;
    } ret_s;

endpackage

`default_nettype wire
